/* files.f */
design/uartPkg.sv
design/hubPkg.sv
design/baudTickGen.sv
design/uartRec.sv
design/rxCollector.sv
design/rxFifo.sv
design/uartRxHub.sv
bench/tbClock.sv
bench/uartRxHub_tb.sv

/* Bender.yml */
package:
  name: uart_rx_hub

sources:
  # packages first, uartPkg is used by hubPkg
  - design/uartPkg.sv
  - design/hubPkg.sv
  # receive path
  - design/baudTickGen.sv
  - design/uartRec.sv
  - design/rxCollector.sv
  - design/rxFifo.sv
  - design/uartRxHub.sv
  # testbench
  - target: test
    files:
      - bench/tbClock.sv
      - bench/uartRxHub_tb.sv

/* bench/uartRxHub_tb.sv */
////////////////////////////////////////////////////////////
// uartRxHub_tb
// table-driven testbench for the receive hub, shapes serial
// frames on the lines and reads the FIFO back with pops
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartRxHub_tb;

	localparam int bitCycles = uartPkg::overSample * uartPkg::tickDivisor;	// 64
	localparam int frameCycles = (uartPkg::dataBits + 2) * bitCycles;		// start, data, stop
	localparam int maxFrames = 11;
	localparam int numRows = 5;
	localparam int driveDelay = 10;			// ns after the rising edge
	localparam int timeoutMargin = 200;		// reset, drain and pops

	// one row of stimulus with its expected records
	typedef struct
	{
		string name;
		logic [hubPkg::numChannels-1:0] mask;		// lines that carry frames
		int frames;									// back-to-back frames per line
		int pops;
		uartPkg::rxByte_t bytes [maxFrames][hubPkg::numChannels];
		hubPkg::rxRecord_t expRec [maxFrames * hubPkg::numChannels];
		int nExp;									// records expected in pop order
		logic expOverflow;
	} testRow_t;

	logic clk;
	logic reset;
	logic [hubPkg::numChannels-1:0] rx;
	logic pop;
	hubPkg::rxRecord_t head;
	logic empty;
	logic overflow;

	testRow_t testTable [numRows];
	int rowCount = 0;
	logic [31:0] lfsrState = 32'hfe09_c971;
	int modelPtr = hubPkg::numChannels - 1;		// last channel served, 0 goes first
	int modelLevel = 0;							// records the FIFO should hold
	int frameSum = 0;
	int timeoutLimit = 0;
	int cycleCount = 0;
	int errorCount = 0;
	string curName = "setup";

	tbClock i_tbClock
	(
		.clk   (clk),
		.reset (reset)
	);

	uartRxHub i_uartRxHub
	(
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.overflow (overflow)
	);

	////////////////////////////////////////////////////////////
	// stimulus helpers
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	function automatic uartPkg::rxByte_t randomByte();
		uartPkg::rxByte_t value;
		for (int k = 0; k < uartPkg::dataBits; k++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value[k] = lfsrState[0];	// one step per bit taken
		end
		return value;
	endfunction

	// fills one row, expected records follow the round-robin drain
	task automatic addRow(input string name, input logic [3:0] mask, input int frames,
		input int pops, input logic expOverflow);
		int start;
		int c;
		hubPkg::rxRecord_t rec;
		testTable[rowCount].name = name;
		testTable[rowCount].mask = mask;
		testTable[rowCount].frames = frames;
		testTable[rowCount].pops = pops;
		testTable[rowCount].expOverflow = expOverflow;
		testTable[rowCount].nExp = 0;
		for (int f = 0; f < maxFrames; f++)
			for (int ch = 0; ch < hubPkg::numChannels; ch++)
				testTable[rowCount].bytes[f][ch] = (f < frames && mask[ch]) ? randomByte() : '0;
		for (int f = 0; f < frames; f++)
		begin
			start = modelPtr;		// all lines finish on one tick
			for (int k = 1; k <= hubPkg::numChannels; k++)
			begin
				c = (start + k) % hubPkg::numChannels;
				if (mask[c])
				begin
					modelPtr = c;	// pointer moves even when the record is dropped
					if (modelLevel < hubPkg::fifoDepth)
					begin
						rec.channel = hubPkg::channel_t'(c);
						rec.data = testTable[rowCount].bytes[f][c];
						testTable[rowCount].expRec[testTable[rowCount].nExp] = rec;
						testTable[rowCount].nExp++;
						modelLevel++;
					end
				end
			end
		end
		modelLevel = (pops >= modelLevel) ? 0 : modelLevel - pops;
		frameSum += frames * frameCycles;
		rowCount++;
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("FAIL %s %s: expected %h actual %h", curName, what, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// start bit, data LSB first, stop bit on every masked line at once
	task automatic sendFrames(input int r);
		logic [hubPkg::numChannels-1:0] lineBits;
		for (int f = 0; f < testTable[r].frames; f++)
		begin
			for (int b = 0; b < uartPkg::dataBits + 2; b++)
			begin
				for (int ch = 0; ch < hubPkg::numChannels; ch++)
				begin
					if (!testTable[r].mask[ch])
						lineBits[ch] = 1'b1;		// idle line
					else if (b == 0)
						lineBits[ch] = 1'b0;		// start
					else if (b == uartPkg::dataBits + 1)
						lineBits[ch] = 1'b1;		// stop
					else
						lineBits[ch] = testTable[r].bytes[f][ch][b-1];
				end
				rx = lineBits;
				repeat (bitCycles) @(posedge clk);
				#driveDelay;
			end
		end
	endtask

	// first record shows up, the rest drain within numChannels cycles
	task automatic waitForData();
		while (empty)
		begin
			@(posedge clk);
			#driveDelay;
		end
		repeat (hubPkg::numChannels + 1) @(posedge clk);
		#driveDelay;
	endtask

	task automatic runRow(input int r);
		curName = testTable[r].name;
		checkValue("empty at start", 1, empty);
		sendFrames(r);
		if (testTable[r].nExp > 0)
			waitForData();
		checkValue("overflow before pops", testTable[r].expOverflow, overflow);
		for (int p = 0; p < testTable[r].pops; p++)
		begin
			if (p < testTable[r].nExp)
			begin
				checkValue($sformatf("empty before pop %0d", p), 0, empty);
				checkValue($sformatf("record %0d", p), testTable[r].expRec[p], head);
			end
			pop = 1'b1;
			@(posedge clk);
			#driveDelay;
			pop = 1'b0;
		end
		checkValue("empty after pops", 1, empty);
		checkValue("overflow after pops", testTable[r].expOverflow, overflow);
	endtask

	////////////////////////////////////////////////////////////
	// run limit
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		rx = '1;		// lines idle high
		pop = 1'b0;
		addRow("resetIdle", 4'b0000, 0, 1, 1'b0);		// pop while empty
		addRow("singleFrame", 4'b0100, 1, 1, 1'b0);
		addRow("allFour", 4'b1111, 1, 4, 1'b0);			// pointer on 2, so 3 0 1 2
		addRow("backToBack", 4'b0010, 2, 2, 1'b0);
		addRow("overflowFill", 4'b0001, 11, 8, 1'b1);	// three records lost
		timeoutLimit = 2 * frameSum + timeoutMargin;

		wait (!reset);
		@(posedge clk);
		#driveDelay;
		curName = "afterReset";
		checkValue("empty", 1, empty);
		checkValue("overflow", 0, overflow);

		for (int r = 0; r < rowCount; r++)
			runRow(r);

		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tbClock.sv */
////////////////////////////////////////////////////////////
// tbClock
// testbench clock, 100 ns period, and a reset held high
// for the first five rising edges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tbClock
(
	output logic clk,
	output logic reset
);

	localparam int halfPeriod = 50;		// ns
	localparam int resetCycles = 5;
	localparam int releaseDelay = 10;	// same offset as the stimulus

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#releaseDelay;
		reset = 1'b0;		// release just after an edge
	end

endmodule

`default_nettype wire

/* design/uartRxHub.sv */
////////////////////////////////////////////////////////////
// uartRxHub
// four-line serial receive hub, tick and synchronizers,
// one receiver per line, collector and receive FIFO
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartRxHub
(
	input  logic clk,
	input  logic reset,
	input  logic [hubPkg::numChannels-1:0] rx,		// serial lines, idle high
	input  logic pop,								// host read strobe
	output hubPkg::rxRecord_t head,					// oldest record
	output logic empty,
	output logic overflow							// a record was lost
);

	logic sTick;										// shared oversampling tick
	logic [hubPkg::numChannels-1:0] rxSync;				// lines after two flops
	logic [hubPkg::numChannels-1:0] doneTick;			// frame done per line
	uartPkg::rxByte_t data [hubPkg::numChannels];		// byte per line
	logic push;
	hubPkg::rxRecord_t pushRecord;

	////////////////////////////////////////////////////////////
	// front end
	baudTickGen i_baudTickGen
	(
		.clk    (clk),
		.reset  (reset),
		.rx     (rx),
		.sTick  (sTick),
		.rxSync (rxSync)
	);

	// one receiver per line
	for (genvar i = 0; i < hubPkg::numChannels; i++)
	begin : recGen
		uartRec i_uartRec
		(
			.clk        (clk),
			.reset      (reset),
			.sTick      (sTick),
			.rx         (rxSync[i]),
			.rxDoneTick (doneTick[i]),
			.dOut       (data[i])
		);
	end

	////////////////////////////////////////////////////////////
	// drain and buffer
	rxCollector i_rxCollector
	(
		.clk        (clk),
		.reset      (reset),
		.doneTick   (doneTick),
		.data       (data),
		.push       (push),
		.pushRecord (pushRecord)
	);

	rxFifo i_rxFifo
	(
		.clk        (clk),
		.reset      (reset),
		.push       (push),
		.pushRecord (pushRecord),
		.pop        (pop),
		.head       (head),
		.empty      (empty),
		.overflow   (overflow)
	);

endmodule

`default_nettype wire

/* design/rxFifo.sv */
////////////////////////////////////////////////////////////
// rxFifo
// circular buffer of tagged receive records with a sticky
// overflow flag for pushes that found it full
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rxFifo
(
	input  logic clk,
	input  logic reset,
	input  logic push,							// write strobe from collector
	input  hubPkg::rxRecord_t pushRecord,
	input  logic pop,							// host read strobe
	output hubPkg::rxRecord_t head,				// oldest record
	output logic empty,
	output logic overflow						// sticky until reset
);

	hubPkg::rxRecord_t mem [hubPkg::fifoDepth];		// storage
	logic [$clog2(hubPkg::fifoDepth)-1:0] rdPtr, wrPtr;
	hubPkg::fifoCount_t level;						// records held
	logic full;
	logic wrEn, rdEn;								// qualified strobes

	// pointer step with wrap at the depth
	function automatic logic [$clog2(hubPkg::fifoDepth)-1:0] nextPtr
	(
		input logic [$clog2(hubPkg::fifoDepth)-1:0] ptr
	);
		if (ptr == hubPkg::fifoDepth - 1)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = (level == '0);
	assign full = (level == hubPkg::fifoCount_t'(hubPkg::fifoDepth));
	assign rdEn = pop && !empty;				// pop while empty is ignored
	assign wrEn = push && (!full || rdEn);		// full with pop frees a slot
	assign head = mem[rdPtr];

	////////////////////////////////////////////////////////////
	// pointers, level and overflow
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			level <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= nextPtr(wrPtr);
			if (rdEn)
				rdPtr <= nextPtr(rdPtr);
			if (wrEn && !rdEn)
				level <= level + 1'b1;
			else if (rdEn && !wrEn)
				level <= level - 1'b1;
			if (push && !wrEn)
				overflow <= 1'b1;		// record dropped
		end
	end

	// storage write
	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrPtr] <= pushRecord;
	end

	levelInRange: assert property (@(posedge clk) disable iff (reset)
		level <= hubPkg::fifoCount_t'(hubPkg::fifoDepth))
		else $error("FIFO level above depth");

endmodule

`default_nettype wire

/* design/rxCollector.sv */
////////////////////////////////////////////////////////////
// rxCollector
// holds one finished byte per channel and forwards one
// tagged record per cycle in round-robin order
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rxCollector
(
	input  logic clk,
	input  logic reset,
	input  logic [hubPkg::numChannels-1:0] doneTick,		// per-receiver frame done
	input  uartPkg::rxByte_t data [hubPkg::numChannels],	// per-receiver byte
	output logic push,										// record valid this cycle
	output hubPkg::rxRecord_t pushRecord					// channel plus byte
);

	logic [hubPkg::numChannels-1:0] pending;				// slot holds an unsent byte
	uartPkg::rxByte_t pendByte [hubPkg::numChannels];		// captured bytes
	hubPkg::channel_t lastServed;							// round-robin pointer
	hubPkg::channel_t sel;									// channel granted now

	////////////////////////////////////////////////////////////
	// round-robin pick
	// search starts one past the channel served last
	always_comb
	begin : pickNext
		hubPkg::channel_t cand;
		push = 1'b0;
		sel = lastServed;
		cand = lastServed;
		for (int k = 1; k <= hubPkg::numChannels; k++)
		begin
			cand = hubPkg::channel_t'((int'(lastServed) + k) % hubPkg::numChannels);
			if (!push && pending[cand])
			begin
				push = 1'b1;		// first pending one wins
				sel = cand;
			end
		end
	end

	always_comb
	begin
		pushRecord.channel = sel;
		pushRecord.data = pendByte[sel];
	end

	////////////////////////////////////////////////////////////
	// pending flags and pointer
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pending <= '0;
			lastServed <= hubPkg::channel_t'(hubPkg::numChannels - 1);	// channel 0 first
		end
		else
		begin
			for (int i = 0; i < hubPkg::numChannels; i++)
			begin
				if (doneTick[i])
					pending[i] <= 1'b1;					// new byte in slot
				else if (push && sel == hubPkg::channel_t'(i))
					pending[i] <= 1'b0;					// handed to the FIFO
			end
			if (push)
				lastServed <= sel;		// advance past the winner
		end
	end

	// byte slots, written on the receiver's done pulse
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < hubPkg::numChannels; i++)
			if (doneTick[i])
				pendByte[i] <= data[i];
	end

	// a frame landing on a full slot means the drain fell behind
	noSlotOverrun: assert property (@(posedge clk) disable iff (reset)
		(doneTick & pending) == '0)
		else $error("doneTick on a channel whose byte is still pending");

endmodule

`default_nettype wire

/* design/uartRec.sv */
////////////////////////////////////////////////////////////
// uartRec
// oversampling receiver for one serial line, 16 ticks per
// bit, data LSB first, stop bit counted but not tested
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uartRec
(
	input  logic clk,
	input  logic reset,
	input  logic sTick,					// oversampling tick
	input  logic rx,					// synchronized line
	output logic rxDoneTick,			// frame complete, one cycle
	output uartPkg::rxByte_t dOut		// byte of the last frame
);

	uartPkg::rxState_t stateReg, stateNext;		// FSM state
	uartPkg::tickCount_t sReg, sNext;			// ticks within a bit
	uartPkg::bitIndex_t nReg, nNext;			// data bits taken so far
	uartPkg::rxByte_t bReg, bNext;				// shift register

	////////////////////////////////////////////////////////////
	// state registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	// data shifter, only moves in the data state
	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	////////////////////////////////////////////////////////////
	// next state logic
	always_comb
	begin
		stateNext = stateReg;		// hold by default
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;

		case (stateReg)
			uartPkg::idle:
				if (!rx)
				begin
					stateNext = uartPkg::start;		// falling edge, frame begins
					sNext = '0;
				end
			uartPkg::start:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCount_t'(uartPkg::overSample / 2 - 1))
					begin
						stateNext = uartPkg::data;	// middle of start bit
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::data:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCount_t'(uartPkg::overSample - 1))
					begin
						sNext = '0;		// middle of the next bit
						bNext = {rx, bReg[uartPkg::dataBits-1:1]};	// LSB arrives first
						if (nReg == uartPkg::bitIndex_t'(uartPkg::dataBits - 1))
							stateNext = uartPkg::stop;		// last data bit in
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::stop:
				if (sTick)
				begin
					if (sReg == uartPkg::tickCount_t'(uartPkg::sbTick - 1))
					begin
						stateNext = uartPkg::idle;	// line level not checked
						rxDoneTick = 1'b1;			// byte ready in bReg
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = uartPkg::idle;
		endcase
	end

	assign dOut = bReg;		// valid until the next frame shifts

	// done only closes the stop state on a tick, never elsewhere
	doneInStop: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> (stateReg == uartPkg::stop && sTick))
		else $error("rxDoneTick outside the stop state");

	// one pulse per frame for the collector
	doneIsStrobe: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |=> !rxDoneTick)
		else $error("rxDoneTick high two cycles running");

endmodule

`default_nettype wire

/* design/baudTickGen.sv */
////////////////////////////////////////////////////////////
// baudTickGen
// makes the shared oversampling tick and brings every raw
// rx line into the clock domain
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module baudTickGen
(
	input  logic clk,
	input  logic reset,
	input  logic [hubPkg::numChannels-1:0] rx,			// raw lines, idle high
	output logic sTick,									// one cycle every tickDivisor
	output logic [hubPkg::numChannels-1:0] rxSync		// two flops behind rx
);

	logic [$clog2(uartPkg::tickDivisor)-1:0] divCount;	// cycle counter inside one tick
	logic [hubPkg::numChannels-1:0] rxMeta;				// first synchronizer stage

	////////////////////////////////////////////////////////////
	// tick divider
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCount <= '0;
			sTick <= 1'b0;
		end
		else
		begin
			if (divCount == uartPkg::tickDivisor - 1)
				divCount <= '0;				// wrap
			else
				divCount <= divCount + 1'b1;
			sTick <= (divCount == uartPkg::tickDivisor - 1);	// pulse on the wrap
		end
	end

	////////////////////////////////////////////////////////////
	// line synchronizers
	// both stages come out of reset at the idle level so no
	// receiver sees a false start edge
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= '1;
			rxSync <= '1;
		end
		else
		begin
			rxMeta <= rx;		// may go metastable
			rxSync <= rxMeta;	// settled copy for the receivers
		end
	end

	// tick is a single-cycle strobe, receivers count it as one sample
	tickIsStrobe: assert property (@(posedge clk) disable iff (reset) sTick |=> !sTick)
		else $error("sTick high on two consecutive cycles");

endmodule

`default_nettype wire

/* design/hubPkg.sv */
////////////////////////////////////////////////////////////
// hubPkg
// channel count, receive FIFO sizing and the tagged
// record that travels from collector to FIFO
////////////////////////////////////////////////////////////

`default_nettype none

package hubPkg;

	// channels
	localparam int numChannels = 4;		// serial lines on the hub
	typedef logic [1:0] channel_t;		// channel index

	// receive FIFO
	localparam int fifoDepth = 8;		// records held before overflow
	typedef logic [3:0] fifoCount_t;	// fill level, 0 up to fifoDepth

	// one received byte tagged with its source line, 10 bits
	typedef struct packed
	{
		channel_t channel;				// which line it came in on
		uartPkg::rxByte_t data;			// the byte itself
	} rxRecord_t;

	// host sees {channel, data} at head, channel in the upper bits
	// record layout is fixed by the struct order above
	// and shared by collector, FIFO and top level

endpackage

`default_nettype wire

/* design/uartPkg.sv */
////////////////////////////////////////////////////////////
// uartPkg
// serial line constants and types shared by the receivers
// and the tick generator
////////////////////////////////////////////////////////////

`default_nettype none

package uartPkg;

	// frame format
	localparam int dataBits = 8;		// bits per frame, LSB first
	localparam int sbTick = 16;			// ticks counted in the stop state (1 stop bit)

	// oversampling
	localparam int overSample = 16;		// ticks per data bit, start waits half
	localparam int tickDivisor = 4;		// clk cycles per tick, so 64 cycles a bit

	typedef logic [dataBits-1:0] rxByte_t;		// received data
	typedef logic [3:0] tickCount_t;			// oversampling counter
	typedef logic [2:0] bitIndex_t;				// data bit counter

	// receiver FSM
	typedef enum logic [1:0]
	{
		idle,		// line high, waiting for a start edge
		start,		// walking to the middle of the start bit
		data,		// shifting in data bits
		stop		// counting out the stop bit
	} rxState_t;

endpackage

`default_nettype wire
